// File: hdl/scc_params.svh
// Constants of the delay-chain configuration manager
// Widths, geometry, setting layout and Avalon address map
`ifndef SCC_PARAMS_SVH
`define SCC_PARAMS_SVH

// Avalon port
`define SCC_AVL_DATA_WIDTH 32
`define SCC_AVL_ADDR_WIDTH 13

// Memory geometry
`define SCC_READ_DQS_WIDTH 4
`define SCC_DQ_PER_DQS 8
`define SCC_DM_PER_DQS 1
`define SCC_DQ_WIDTH 32
`define SCC_DM_WIDTH 4

// Setting register file and its entry layout
`define SCC_SETTING_BITS 24
`define SCC_RFILE_DEPTH 16
`define SCC_RFILE_LATENCY 3
`define SCC_ENTRY_DQS 0
`define SCC_ENTRY_DQ 4
`define SCC_ENTRY_DQS_IO 12
`define SCC_ENTRY_DM 13

// Address map, section is avl_address[9:6]
`define SCC_BROADCAST 255
`define SCC_SECT_GROUP 0
`define SCC_SECT_SCAN 14
`define SCC_SECT_TRACK 15
`define SCC_TRACK_SAMPLE_INDEX 63

`endif

// File: hdl/scc_pkg.sv
// Shared types of the delay-chain configuration manager
`include "scc_params.svh"

package scc_pkg;

	// Scan command codes as carried in avl_address[3:0]
	typedef enum logic [3:0] {
		SCAN_DQS    = 4'd0,
		SCAN_DQS_IO = 4'd1,
		SCAN_DQ_IO  = 4'd2,
		SCAN_DM_IO  = 4'd3,
		SCAN_UPD    = 4'd8
	} scan_kind_t;

	typedef logic [`SCC_SETTING_BITS-1:0] setting_word_t;

	typedef logic [`SCC_AVL_DATA_WIDTH-1:0] avl_word_t;

	typedef logic [$clog2(`SCC_RFILE_DEPTH)-1:0] rfile_addr_t;

	// Field section, only 1 to 9 name a field
	typedef logic [3:0] field_sel_t;

	typedef logic signed [`SCC_AVL_DATA_WIDTH-1:0] sample_count_t;

endpackage

// File: hdl/scc_avl_port.sv
// Avalon-MM slave side: decode, access phasing, waitrequest and read-back,
// plus the group counter and the captured strobe-tracking bits
`timescale 1ns/10ps
`include "scc_params.svh"

module scc_avl_port (
	input  logic                           avl_clk,
	input  logic                           avl_reset_n,
	input  logic [`SCC_AVL_ADDR_WIDTH-1:0] avl_address,
	input  logic                           avl_write,
	input  logic [`SCC_AVL_DATA_WIDTH-1:0] avl_writedata,
	input  logic                           avl_read,
	output logic [`SCC_AVL_DATA_WIDTH-1:0] avl_readdata,
	output logic                           avl_waitrequest,
	input  logic [`SCC_READ_DQS_WIDTH-1:0] capture_strobe_tracking,
	input  scc_pkg::setting_word_t         word,
	input  scc_pkg::avl_word_t             field_rdata,
	input  logic                           scan_busy,
	input  logic                           scan_done,
	input  scc_pkg::sample_count_t         count [`SCC_READ_DQS_WIDTH],
	output scc_pkg::rfile_addr_t           rfile_addr,
	output scc_pkg::field_sel_t            field_sel,
	output scc_pkg::avl_word_t             field_wdata,
	output logic                           field_wr,
	output logic                           scan_start,
	output scc_pkg::scan_kind_t            scan_kind,
	output logic [7:0]                     scan_select,
	output logic [7:0]                     group_sel,
	output logic [`SCC_READ_DQS_WIDTH-1:0] count_load,
	output logic [`SCC_READ_DQS_WIDTH-1:0] count_step,
	output scc_pkg::sample_count_t         load_value,
	output logic [`SCC_READ_DQS_WIDTH-1:0] step_up
);
	import scc_pkg::*;

	localparam int N = `SCC_READ_DQS_WIDTH;
	localparam int LAT = `SCC_RFILE_LATENCY;
	localparam int IDX_W = $clog2(N);

	logic [3:0] sect;
	logic [5:0] index;
	logic avl_req;
	logic store_req;
	logic group_req;
	logic field_req;
	logic scan_req;
	logic trk_req;
	logic trk_sample;
	logic sel_bcast;
	logic port_up;
	logic [LAT-1:1] acc_stage;
	logic acc_begin;
	logic acc_wr_stage;
	logic acc_end;
	logic trk_phase;
	logic [7:0] group_counter;
	logic [N-1:0] trk_cap;
	rfile_addr_t field_entry;
	rfile_addr_t scan_entry;
	logic [7:0] sel_limit;

	assign sect = avl_address[9:6];
	assign index = avl_address[5:0];
	assign avl_req = avl_read || avl_write;
	assign sel_bcast = avl_writedata[7:0] == 8'(`SCC_BROADCAST);

	// Sections 0 to 13 share the register-file timing, unused ones included
	assign store_req = avl_req && (sect < 4'(`SCC_SECT_SCAN));
	assign group_req = avl_req && (sect == 4'(`SCC_SECT_GROUP));
	assign field_req = avl_req && (sect >= 4'd1) && (sect <= 4'd9);
	assign scan_req = avl_req && (sect == 4'(`SCC_SECT_SCAN));
	assign trk_req = avl_req && (sect == 4'(`SCC_SECT_TRACK));
	assign trk_sample = index == 6'(`SCC_TRACK_SAMPLE_INDEX);

	// Stage 1 is the request cycle itself, the last stage releases the master
	assign acc_begin = store_req && !(|acc_stage);
	assign acc_wr_stage = acc_stage[LAT-2];
	assign acc_end = acc_stage[LAT-1];

	always_ff @(posedge avl_clk or negedge avl_reset_n)
	begin
		if (!avl_reset_n)
		begin
			port_up <= 1'b0;
			acc_stage <= '0;
			trk_phase <= 1'b0;
			group_counter <= '0;
			trk_cap <= '0;
		end
		else
		begin
			port_up <= 1'b1;
			acc_stage <= {acc_stage[LAT-2:1], acc_begin};
			trk_phase <= trk_req && !trk_phase;
			trk_cap <= capture_strobe_tracking;
			if (group_req && avl_write && acc_wr_stage)
				group_counter <= avl_writedata[7:0];
		end
	end

	assign avl_waitrequest = !port_up ||
		(avl_req && !acc_end && !(scan_req && scan_done) && !trk_phase);

	// Sections 7 to 9 address the DQ entries
	assign field_entry = (sect >= 4'd7) ? rfile_addr_t'(`SCC_ENTRY_DQ + index) :
		rfile_addr_t'(index);

	always_comb
	begin
		scan_entry = rfile_addr_t'(`SCC_ENTRY_DQS);
		sel_limit = 8'hff;
		case (scan_kind)
		SCAN_DQS:
		begin
			if (!sel_bcast)
				scan_entry = rfile_addr_t'(`SCC_ENTRY_DQS + scan_select);
			sel_limit = 8'(N);
		end
		SCAN_DQS_IO:
		begin
			scan_entry = rfile_addr_t'(`SCC_ENTRY_DQS_IO);
			sel_limit = 8'd1;
		end
		SCAN_DQ_IO:
		begin
			scan_entry = sel_bcast ? rfile_addr_t'(`SCC_ENTRY_DQ) :
				rfile_addr_t'(`SCC_ENTRY_DQ + scan_select);
			sel_limit = 8'(`SCC_DQ_PER_DQS);
		end
		SCAN_DM_IO:
		begin
			scan_entry = rfile_addr_t'(`SCC_ENTRY_DM);
			sel_limit = 8'(`SCC_DM_PER_DQS);
		end
		default:
			sel_limit = 8'hff;
		endcase
	end

	assign scan_kind = scan_kind_t'(avl_address[3:0]);
	assign scan_select = avl_writedata[7:0];
	assign group_sel = group_counter;
	assign scan_start = scan_req && !scan_busy;

	assign rfile_addr = scan_req ? scan_entry : field_entry;
	assign field_sel = sect;
	assign field_wdata = avl_writedata;
	assign field_wr = field_req && avl_write && acc_wr_stage;

	assign load_value = sample_count_t'(avl_writedata);
	assign step_up = trk_cap;

	// Loads and samples land at the end of the second tracking cycle
	always_comb
	begin
		for (int i = 0; i < N; i++)
		begin
			count_load[i] = trk_phase && avl_write && !trk_sample && (index == 6'(i));
			count_step[i] = trk_phase && avl_write && trk_sample &&
				(sel_bcast || avl_writedata[7:0] == 8'(i));
		end
	end

	always_comb
	begin
		avl_readdata = '0;
		if (group_req)
			avl_readdata = avl_word_t'(group_counter);
		else if (field_req)
			avl_readdata = field_rdata;
		else if (scan_req)
			avl_readdata = avl_word_t'(word);  // the word being scanned
		else if (trk_req && index < 6'(N))
			avl_readdata = count[index[IDX_W-1:0]];
	end

	// A scan command carries a broadcast or an in-range select for its kind
	a_scan_select: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		scan_start |-> (scan_select == 8'(`SCC_BROADCAST)) || (scan_select < sel_limit));

	// Tracking accesses other than a sample address an existing counter
	a_track_index: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		(trk_req && !trk_sample) |-> (index < 6'(N)));

endmodule

// File: hdl/scc_setting_store.sv
// Setting register file with registered read and field read-modify-write
`timescale 1ns/10ps
`include "scc_params.svh"

module scc_setting_store (
	input  logic                   avl_clk,
	input  logic                   avl_reset_n,
	input  scc_pkg::rfile_addr_t   rfile_addr,
	input  scc_pkg::field_sel_t    field_sel,
	input  scc_pkg::avl_word_t     field_wdata,
	input  logic                   field_wr,
	output scc_pkg::setting_word_t word,
	output scc_pkg::avl_word_t     field_rdata
);
	import scc_pkg::*;

	localparam int SB = `SCC_SETTING_BITS;

	// Bit offset and width of each field section
	localparam int FIELD_OFS [1:9] = '{0, 4, 8, 12, 17, 21, 0, 4, 7};
	localparam int FIELD_WID [1:9] = '{4, 4, 4, 5, 4, 3, 4, 3, 4};

	setting_word_t mem [`SCC_RFILE_DEPTH];
	logic field_ok;
	int ofs;
	setting_word_t lane_mask;
	setting_word_t field_mask;
	setting_word_t merged;

	always_comb
	begin
		field_ok = (field_sel >= 4'd1) && (field_sel <= 4'd9);
		ofs = 0;
		lane_mask = '0;
		if (field_ok)
		begin
			ofs = FIELD_OFS[field_sel];
			lane_mask = ~({SB{1'b1}} << FIELD_WID[field_sel]);
		end
		field_mask = lane_mask << ofs;

		// Only the addressed field changes, the rest of the word is kept
		merged = (word & ~field_mask) | ((field_wdata[SB-1:0] & lane_mask) << ofs);
		field_rdata = avl_word_t'((word >> ofs) & lane_mask);
	end

	always_ff @(posedge avl_clk)
	begin
		if (field_wr)
			mem[rfile_addr] <= merged;
		word <= mem[rfile_addr];
	end

	// The port only writes back through a named field section
	a_field_sel: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		field_wr |-> field_ok);

endmodule

// File: hdl/strobe_sample_counter.sv
// Saturating signed up/down sample counter for one read DQS group
`timescale 1ns/10ps

module strobe_sample_counter (
	input  logic                   avl_clk,
	input  logic                   avl_reset_n,
	input  logic                   count_load,
	input  logic                   count_step,
	input  scc_pkg::sample_count_t load_value,
	input  logic                   step_up,
	output scc_pkg::sample_count_t count
);
	import scc_pkg::*;

	localparam int CW = $bits(sample_count_t);
	localparam sample_count_t COUNT_MAX = {1'b0, {(CW-1){1'b1}}};
	localparam sample_count_t COUNT_MIN = {1'b1, {(CW-1){1'b0}}};

	always_ff @(posedge avl_clk or negedge avl_reset_n)
	begin
		if (!avl_reset_n)
			count <= '0;
		else if (count_load)
			count <= load_value;
		else if (count_step)
		begin
			// Hold at either extreme instead of wrapping
			if (step_up && count != COUNT_MAX)
				count <= count + 1;
			else if (!step_up && count != COUNT_MIN)
				count <= count - 1;
		end
	end

endmodule

// File: hdl/scc_scan_engine.sv
// Scan engine: shifts a setting word out MSB first with its pin enables,
// or pulses the update strobe
`timescale 1ns/10ps
`include "scc_params.svh"

module scc_scan_engine (
	input  logic                           avl_clk,
	input  logic                           avl_reset_n,
	input  logic                           scan_start,
	input  scc_pkg::scan_kind_t            scan_kind,
	input  logic [7:0]                     scan_select,
	input  logic [7:0]                     group_sel,
	input  scc_pkg::setting_word_t         word,
	output logic                           scan_busy,
	output logic                           scan_done,
	output logic                           scc_data,
	output logic [`SCC_READ_DQS_WIDTH-1:0] scc_dqs_ena,
	output logic [`SCC_READ_DQS_WIDTH-1:0] scc_dqs_io_ena,
	output logic [`SCC_DQ_WIDTH-1:0]       scc_dq_ena,
	output logic [`SCC_DM_WIDTH-1:0]       scc_dm_ena,
	output logic                           scc_upd
);
	import scc_pkg::*;

	localparam int R = `SCC_READ_DQS_WIDTH;
	localparam int DQ = `SCC_DQ_WIDTH;
	localparam int DM = `SCC_DM_WIDTH;
	localparam int SB = `SCC_SETTING_BITS;
	localparam int CNT_W = $clog2(SB);
	localparam logic [R-1:0] ONE_R = 1;
	localparam logic [DQ-1:0] ONE_DQ = 1;
	localparam logic [DQ-1:0] DQ_LANE = {`SCC_DQ_PER_DQS{1'b1}};
	localparam logic [DM-1:0] ONE_DM = 1;
	localparam logic [DM-1:0] DM_LANE = {`SCC_DM_PER_DQS{1'b1}};

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_SHIFT,
		ST_UPDATE,
		ST_DONE
	} scan_state_t;

	scan_state_t state;
	scan_kind_t cmd_kind;
	logic [7:0] cmd_select;
	logic [7:0] cmd_group;
	setting_word_t shift_reg;
	logic [CNT_W-1:0] bit_cnt;
	logic cmd_bcast;
	logic [R-1:0] dqs_dec;
	logic [R-1:0] dqs_io_dec;
	logic [DQ-1:0] dq_dec;
	logic [DM-1:0] dm_dec;

	assign scan_busy = state != ST_IDLE;
	assign scan_done = state == ST_DONE;

	// Enable pattern of the latched command
	always_comb
	begin
		cmd_bcast = cmd_select == 8'(`SCC_BROADCAST);
		dqs_dec = '0;
		dqs_io_dec = '0;
		dq_dec = '0;
		dm_dec = '0;
		case (cmd_kind)
		SCAN_DQS:
			dqs_dec = cmd_bcast ? '1 : ONE_R << cmd_select;
		SCAN_DQS_IO:
			dqs_io_dec = cmd_bcast ? '1 : ONE_R << cmd_group;
		SCAN_DQ_IO:
			dq_dec = cmd_bcast ? DQ_LANE << (cmd_group * `SCC_DQ_PER_DQS) :
				ONE_DQ << (cmd_group * `SCC_DQ_PER_DQS + cmd_select);
		SCAN_DM_IO:
			dm_dec = cmd_bcast ? DM_LANE << (cmd_group * `SCC_DM_PER_DQS) :
				ONE_DM << (cmd_group * `SCC_DM_PER_DQS + cmd_select);
		// Update and unknown codes enable no pins
		default:
			dqs_dec = '0;
		endcase
	end

	always_ff @(posedge avl_clk or negedge avl_reset_n)
	begin
		if (!avl_reset_n)
		begin
			state <= ST_IDLE;
			cmd_kind <= SCAN_DQS;
			bit_cnt <= '0;
			scc_data <= 1'b0;
			scc_dqs_ena <= '0;
			scc_dqs_io_ena <= '0;
			scc_dq_ena <= '0;
			scc_dm_ena <= '0;
			scc_upd <= 1'b0;
		end
		else
		begin
			case (state)
			ST_IDLE:
				if (scan_start)
				begin
					cmd_kind <= scan_kind;
					scc_upd <= scan_kind == SCAN_UPD;
					state <= (scan_kind == SCAN_UPD) ? ST_UPDATE : ST_LOAD;
				end
			ST_LOAD:
			begin
				// First bit and the enables go out together
				scc_data <= word[SB-1];
				scc_dqs_ena <= dqs_dec;
				scc_dqs_io_ena <= dqs_io_dec;
				scc_dq_ena <= dq_dec;
				scc_dm_ena <= dm_dec;
				bit_cnt <= CNT_W'(SB - 1);
				state <= ST_SHIFT;
			end
			ST_SHIFT:
				if (bit_cnt == '0)
				begin
					scc_data <= 1'b0;
					scc_dqs_ena <= '0;
					scc_dqs_io_ena <= '0;
					scc_dq_ena <= '0;
					scc_dm_ena <= '0;
					state <= ST_DONE;
				end
				else
				begin
					scc_data <= shift_reg[SB-1];
					bit_cnt <= bit_cnt - 1'b1;
				end
			ST_UPDATE:
			begin
				scc_upd <= 1'b0;
				state <= ST_DONE;
			end
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	// Command operands and the word being shifted
	always_ff @(posedge avl_clk)
	begin
		if (state == ST_IDLE && scan_start)
		begin
			cmd_select <= scan_select;
			cmd_group <= group_sel;
		end
		if (state == ST_LOAD)
			shift_reg <= word << 1;
		else if (state == ST_SHIFT)
			shift_reg <= shift_reg << 1;
	end

	// The port never requests a scan while one is in flight
	a_start_idle: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		scan_start |-> state == ST_IDLE);

endmodule

// File: hdl/scc_mgr.sv
// Delay-chain configuration manager for the DDR PHY sequencer
// Avalon port, setting store, scan engine and per-group sample counters
`timescale 1ns/10ps
`include "scc_params.svh"

module scc_mgr (
	input  logic                           avl_clk,
	input  logic                           avl_reset_n,
	input  logic [`SCC_AVL_ADDR_WIDTH-1:0] avl_address,
	input  logic                           avl_write,
	input  logic [`SCC_AVL_DATA_WIDTH-1:0] avl_writedata,
	input  logic                           avl_read,
	output logic [`SCC_AVL_DATA_WIDTH-1:0] avl_readdata,
	output logic                           avl_waitrequest,
	output logic                           scc_data,
	output logic [`SCC_READ_DQS_WIDTH-1:0] scc_dqs_ena,
	output logic [`SCC_READ_DQS_WIDTH-1:0] scc_dqs_io_ena,
	output logic [`SCC_DQ_WIDTH-1:0]       scc_dq_ena,
	output logic [`SCC_DM_WIDTH-1:0]       scc_dm_ena,
	output logic                           scc_upd,
	input  logic [`SCC_READ_DQS_WIDTH-1:0] capture_strobe_tracking
);
	import scc_pkg::*;

	rfile_addr_t rfile_addr;
	field_sel_t field_sel;
	avl_word_t field_wdata;
	avl_word_t field_rdata;
	logic field_wr;
	setting_word_t word;
	logic scan_start;
	logic scan_busy;
	logic scan_done;
	scan_kind_t scan_kind;
	logic [7:0] scan_select;
	logic [7:0] group_sel;
	logic [`SCC_READ_DQS_WIDTH-1:0] count_load;
	logic [`SCC_READ_DQS_WIDTH-1:0] count_step;
	logic [`SCC_READ_DQS_WIDTH-1:0] step_up;
	sample_count_t load_value;
	sample_count_t count [`SCC_READ_DQS_WIDTH];

	scc_avl_port avl_port_i (
		.avl_clk                 (avl_clk),
		.avl_reset_n             (avl_reset_n),
		.avl_address             (avl_address),
		.avl_write               (avl_write),
		.avl_writedata           (avl_writedata),
		.avl_read                (avl_read),
		.avl_readdata            (avl_readdata),
		.avl_waitrequest         (avl_waitrequest),
		.capture_strobe_tracking (capture_strobe_tracking),
		.word                    (word),
		.field_rdata             (field_rdata),
		.scan_busy               (scan_busy),
		.scan_done               (scan_done),
		.count                   (count),
		.rfile_addr              (rfile_addr),
		.field_sel               (field_sel),
		.field_wdata             (field_wdata),
		.field_wr                (field_wr),
		.scan_start              (scan_start),
		.scan_kind               (scan_kind),
		.scan_select             (scan_select),
		.group_sel               (group_sel),
		.count_load              (count_load),
		.count_step              (count_step),
		.load_value              (load_value),
		.step_up                 (step_up)
	);

	scc_setting_store setting_store_i (
		.avl_clk     (avl_clk),
		.avl_reset_n (avl_reset_n),
		.rfile_addr  (rfile_addr),
		.field_sel   (field_sel),
		.field_wdata (field_wdata),
		.field_wr    (field_wr),
		.word        (word),
		.field_rdata (field_rdata)
	);

	scc_scan_engine scan_engine_i (
		.avl_clk        (avl_clk),
		.avl_reset_n    (avl_reset_n),
		.scan_start     (scan_start),
		.scan_kind      (scan_kind),
		.scan_select    (scan_select),
		.group_sel      (group_sel),
		.word           (word),
		.scan_busy      (scan_busy),
		.scan_done      (scan_done),
		.scc_data       (scc_data),
		.scc_dqs_ena    (scc_dqs_ena),
		.scc_dqs_io_ena (scc_dqs_io_ena),
		.scc_dq_ena     (scc_dq_ena),
		.scc_dm_ena     (scc_dm_ena),
		.scc_upd        (scc_upd)
	);

	// One tracking counter per read DQS group
	for (genvar g = 0; g < `SCC_READ_DQS_WIDTH; g++)
	begin : g_counter
		strobe_sample_counter counter_i (
			.avl_clk     (avl_clk),
			.avl_reset_n (avl_reset_n),
			.count_load  (count_load[g]),
			.count_step  (count_step[g]),
			.load_value  (load_value),
			.step_up     (step_up[g]),
			.count       (count[g])
		);
	end

endmodule

// File: verification/scc_mgr_tb.sv
// Testbench for the delay-chain configuration manager
// Random field, counter and scan traffic checked against a reference model
`timescale 1ns/10ps
`include "scc_params.svh"

module scc_mgr_tb;

	localparam int N = `SCC_READ_DQS_WIDTH;
	localparam int NUM_FIELD = 60;
	localparam int NUM_GROUP = 8;
	localparam int NUM_SAMPLE = 40;
	localparam int NUM_SCAN = 24;
	localparam int NUM_UPD = 4;
	// Reset reads, store fill, fields, group, counters, saturation, scans
	localparam int NUM_ACCESS = 5 + 96 + NUM_FIELD * 3 + NUM_GROUP * 2 + 8 +
		NUM_SAMPLE * 5 + 18 + NUM_SCAN * 2 + NUM_UPD;
	localparam longint WATCHDOG_NS = longint'(NUM_ACCESS * 40 + 200) * 20;

	// Offset and width of field sections 1 to 9
	localparam int FIELD_OFS [1:9] = '{0, 4, 8, 12, 17, 21, 0, 4, 7};
	localparam int FIELD_WID [1:9] = '{4, 4, 4, 5, 4, 3, 4, 3, 4};

	logic avl_clk;
	logic avl_reset_n;
	logic [`SCC_AVL_ADDR_WIDTH-1:0] avl_address;
	logic avl_write;
	logic [`SCC_AVL_DATA_WIDTH-1:0] avl_writedata;
	logic avl_read;
	logic [`SCC_AVL_DATA_WIDTH-1:0] avl_readdata;
	logic avl_waitrequest;
	logic scc_data;
	logic [N-1:0] scc_dqs_ena;
	logic [N-1:0] scc_dqs_io_ena;
	logic [`SCC_DQ_WIDTH-1:0] scc_dq_ena;
	logic [`SCC_DM_WIDTH-1:0] scc_dm_ena;
	logic scc_upd;
	logic [N-1:0] capture_strobe_tracking;

	// Reference model
	logic [`SCC_SETTING_BITS-1:0] model_word [`SCC_RFILE_DEPTH];
	logic [7:0] model_group;
	logic [31:0] model_count [N];

	integer seed;
	int errors;
	int checks;
	logic scan_bits [$];
	int upd_cycles;
	logic [43:0] exp_ena;

	scc_mgr scc_mgr_i (
		.avl_clk                 (avl_clk),
		.avl_reset_n             (avl_reset_n),
		.avl_address             (avl_address),
		.avl_write               (avl_write),
		.avl_writedata           (avl_writedata),
		.avl_read                (avl_read),
		.avl_readdata            (avl_readdata),
		.avl_waitrequest         (avl_waitrequest),
		.scc_data                (scc_data),
		.scc_dqs_ena             (scc_dqs_ena),
		.scc_dqs_io_ena          (scc_dqs_io_ena),
		.scc_dq_ena              (scc_dq_ena),
		.scc_dm_ena              (scc_dm_ena),
		.scc_upd                 (scc_upd),
		.capture_strobe_tracking (capture_strobe_tracking)
	);

	initial
	begin
		avl_clk = 1'b0;
		forever
			#10 avl_clk = ~avl_clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	task automatic check_word(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// Collects scan pins once per cycle while an access is in flight
	task automatic watch_scan_pins();
		logic [43:0] ena;
		ena = {scc_dqs_ena, scc_dqs_io_ena, scc_dq_ena, scc_dm_ena};
		if (scc_upd)
			upd_cycles++;
		if (ena != '0)
		begin
			scan_bits.push_back(scc_data);
			check_word("scan enables", exp_ena, ena);
		end
	endtask

	// Holds the request until waitrequest drops and samples at each falling edge
	task automatic bus_access(input logic wr, input logic [3:0] sect, input logic [5:0] index,
		input logic [31:0] wdata, output logic [31:0] rdata, output int cycles);
		avl_address = {3'b000, sect, index};
		avl_writedata = wdata;
		avl_write = wr;
		avl_read = !wr;
		cycles = 0;
		do
		begin
			@(negedge avl_clk);
			watch_scan_pins();
			cycles++;
		end
		while (avl_waitrequest);
		rdata = avl_readdata;
		@(posedge avl_clk);
		#2;
		avl_write = 1'b0;
		avl_read = 1'b0;
	endtask

	task automatic store_access(input logic wr, input logic [3:0] sect, input logic [5:0] index,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int cycles;
		bus_access(wr, sect, index, wdata, rdata, cycles);
		check_word("store latency", `SCC_RFILE_LATENCY, cycles);
	endtask

	task automatic track_access(input logic wr, input logic [5:0] index,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int cycles;
		bus_access(wr, 4'(`SCC_SECT_TRACK), index, wdata, rdata, cycles);
		check_word("tracking latency", 2, cycles);
	endtask

	function automatic logic [3:0] field_entry(input logic [3:0] sect, input logic [5:0] index);
		logic [3:0] entry;
		entry = index[3:0];
		// DQ sections count from the first DQ entry
		if (sect >= 4'd7)
			entry = 4'(`SCC_ENTRY_DQ + index);
		return entry;
	endfunction

	function automatic logic [`SCC_SETTING_BITS-1:0] field_mask(input logic [3:0] sect);
		return `SCC_SETTING_BITS'((1 << FIELD_WID[sect]) - 1);
	endfunction

	task automatic write_field(input logic [3:0] sect, input logic [5:0] index,
		input logic [31:0] value);
		logic [31:0] unused;
		logic [3:0] entry;
		logic [`SCC_SETTING_BITS-1:0] mask;
		store_access(1'b1, sect, index, value, unused);
		entry = field_entry(sect, index);
		mask = field_mask(sect);
		model_word[entry] = (model_word[entry] & ~(mask << FIELD_OFS[sect])) |
			((value[`SCC_SETTING_BITS-1:0] & mask) << FIELD_OFS[sect]);
	endtask

	task automatic check_field(input logic [3:0] sect, input logic [5:0] index);
		logic [31:0] rdata;
		logic [3:0] entry;
		store_access(1'b0, sect, index, 32'h0, rdata);
		entry = field_entry(sect, index);
		check_word($sformatf("field %0d.%0d", sect, index),
			32'((model_word[entry] >> FIELD_OFS[sect]) & field_mask(sect)), rdata);
	endtask

	function automatic logic [31:0] step_count(input logic [31:0] value, input logic up);
		logic [31:0] result;
		result = value;
		// Signed extremes hold
		if (up && value != 32'h7fff_ffff)
			result = value + 32'd1;
		else if (!up && value != 32'h8000_0000)
			result = value - 32'd1;
		return result;
	endfunction

	task automatic compare_counters(input string name);
		logic [31:0] rdata;
		for (int i = 0; i < N; i++)
		begin
			track_access(1'b0, 6'(i), 32'h0, rdata);
			check_word($sformatf("%s %0d", name, i), model_count[i], rdata);
		end
	endtask

	task automatic preset_counter(input int i, input logic [31:0] value);
		logic [31:0] unused;
		track_access(1'b1, 6'(i), value, unused);
		model_count[i] = value;
	endtask

	task automatic load_counters(input logic [31:0] value);
		for (int i = 0; i < N; i++)
			preset_counter(i, value);
	endtask

	task automatic sample_counters(input logic [7:0] sel);
		logic [31:0] unused;
		track_access(1'b1, 6'(`SCC_TRACK_SAMPLE_INDEX), {24'h0, sel}, unused);
		for (int i = 0; i < N; i++)
			if (sel == 8'(`SCC_BROADCAST) || sel == 8'(i))
				model_count[i] = step_count(model_count[i], capture_strobe_tracking[i]);
	endtask

	function automatic logic [43:0] scan_enables(input int kind, input logic bcast,
		input logic [7:0] sel, input int group);
		logic [N-1:0] dqs;
		logic [N-1:0] dqs_io;
		logic [`SCC_DQ_WIDTH-1:0] dq;
		logic [`SCC_DM_WIDTH-1:0] dm;
		dqs = '0;
		dqs_io = '0;
		dq = '0;
		dm = '0;
		case (kind)
		0: dqs = bcast ? 4'hf : 4'(1 << sel);
		1: dqs_io = bcast ? 4'hf : 4'(1 << group);
		2: dq = bcast ? 32'hff << (group * `SCC_DQ_PER_DQS) :
			32'h1 << (group * `SCC_DQ_PER_DQS + sel);
		default: dm = 4'(1 << group);
		endcase
		return {dqs, dqs_io, dq, dm};
	endfunction

	function automatic logic [3:0] source_entry(input int kind, input logic bcast,
		input logic [7:0] sel);
		logic [3:0] entry;
		case (kind)
		0: entry = bcast ? 4'(`SCC_ENTRY_DQS) : 4'(`SCC_ENTRY_DQS + sel);
		1: entry = 4'(`SCC_ENTRY_DQS_IO);
		2: entry = bcast ? 4'(`SCC_ENTRY_DQ) : 4'(`SCC_ENTRY_DQ + sel);
		default: entry = 4'(`SCC_ENTRY_DM);
		endcase
		return entry;
	endfunction

	task automatic reset_checks();
		logic [31:0] rdata;
		repeat (10)
		begin
			@(negedge avl_clk);
			check_word("waitrequest during reset", 1, avl_waitrequest);
		end
		@(posedge avl_clk);
		#2;
		avl_reset_n = 1'b1;
		@(negedge avl_clk);
		check_word("scan pins after reset", 0,
			{scc_data, scc_upd, scc_dqs_ena, scc_dqs_io_ena, scc_dq_ena, scc_dm_ena});
		@(posedge avl_clk);
		#2;
		store_access(1'b0, 4'(`SCC_SECT_GROUP), 6'd0, 32'h0, rdata);
		check_word("group after reset", 0, rdata);
		compare_counters("counter after reset");
	endtask

	// Sections 1 to 6 together cover every bit of an entry
	task automatic fill_store();
		for (int entry = 0; entry < `SCC_RFILE_DEPTH; entry++)
			for (int s = 1; s <= 6; s++)
				write_field(4'(s), 6'(entry), $random(seed));
	endtask

	task automatic field_traffic();
		int sect;
		int index;
		logic [3:0] entry;
		for (int n = 0; n < NUM_FIELD; n++)
		begin
			sect = 1 + rand_below(9);
			index = (sect >= 7) ? rand_below(`SCC_DQ_PER_DQS) : rand_below(`SCC_RFILE_DEPTH);
			write_field(4'(sect), 6'(index), $random(seed));
			check_field(4'(sect), 6'(index));
			// Another field of the same entry must be untouched
			entry = field_entry(4'(sect), 6'(index));
			check_field(4'(1 + rand_below(6)), 6'(entry));
		end
	endtask

	task automatic group_traffic();
		logic [31:0] value;
		logic [31:0] rdata;
		for (int n = 0; n < NUM_GROUP; n++)
		begin
			value = $random(seed);
			store_access(1'b1, 4'(`SCC_SECT_GROUP), 6'd0, value, rdata);
			model_group = value[7:0];
			store_access(1'b0, 4'(`SCC_SECT_GROUP), 6'd0, 32'h0, rdata);
			check_word("group counter", {24'h0, model_group}, rdata);
		end
	endtask

	task automatic counter_traffic();
		logic [7:0] sel;
		// Each counter starts from its own value
		for (int i = 0; i < N; i++)
			preset_counter(i, $random(seed));
		compare_counters("counter load");
		for (int n = 0; n < NUM_SAMPLE; n++)
		begin
			// Tracking bits are held through the whole sample access
			capture_strobe_tracking = 4'($random(seed));
			sel = (rand_below(4) == 0) ? 8'(`SCC_BROADCAST) : 8'(rand_below(N));
			sample_counters(sel);
			compare_counters("counter sample");
		end
	endtask

	task automatic saturation_check();
		load_counters(32'h7fff_ffff);
		capture_strobe_tracking = '1;
		sample_counters(8'(`SCC_BROADCAST));
		compare_counters("saturate high");
		load_counters(32'h8000_0000);
		capture_strobe_tracking = '0;
		sample_counters(8'(`SCC_BROADCAST));
		compare_counters("saturate low");
	endtask

	task automatic shift_scans();
		int kind;
		int group;
		int cycles;
		logic bcast;
		logic [7:0] sel;
		logic [3:0] entry;
		logic [31:0] rdata;
		logic [`SCC_SETTING_BITS-1:0] shifted;
		for (int n = 0; n < NUM_SCAN; n++)
		begin
			group = rand_below(N);
			store_access(1'b1, 4'(`SCC_SECT_GROUP), 6'd0, 32'(group), rdata);
			model_group = 8'(group);
			kind = n % 4;
			bcast = rand_below(4) == 0;
			case (kind)
			0: sel = 8'(rand_below(N));
			2: sel = 8'(rand_below(`SCC_DQ_PER_DQS));
			default: sel = 8'd0;
			endcase
			if (bcast)
				sel = 8'(`SCC_BROADCAST);
			exp_ena = scan_enables(kind, bcast, sel, group);
			entry = source_entry(kind, bcast, sel);
			scan_bits.delete();
			upd_cycles = 0;
			bus_access(1'b1, 4'(`SCC_SECT_SCAN), 6'(kind), {24'h0, sel}, rdata, cycles);
			// Request, load, 24 shifts and done
			check_word("scan latency", 27, cycles);
			check_word("scan bit count", `SCC_SETTING_BITS, scan_bits.size());
			shifted = '0;
			foreach (scan_bits[i])
				shifted = {shifted[`SCC_SETTING_BITS-2:0], scan_bits[i]};
			check_word($sformatf("scan kind %0d data", kind), model_word[entry], shifted);
			check_word("scan update pulses", 0, upd_cycles);
		end
	endtask

	task automatic update_scans();
		int cycles;
		logic [31:0] rdata;
		for (int n = 0; n < NUM_UPD; n++)
		begin
			exp_ena = '0;
			scan_bits.delete();
			upd_cycles = 0;
			bus_access(1'b1, 4'(`SCC_SECT_SCAN), 6'd8, 32'($random(seed) & 32'hff),
				rdata, cycles);
			check_word("update latency", 3, cycles);
			check_word("update pulses", 1, upd_cycles);
			check_word("update enable cycles", 0, scan_bits.size());
		end
	endtask

	initial
	begin
		seed = 60028;
		errors = 0;
		checks = 0;
		upd_cycles = 0;
		exp_ena = '0;
		model_group = '0;
		for (int i = 0; i < N; i++)
			model_count[i] = '0;
		for (int i = 0; i < `SCC_RFILE_DEPTH; i++)
			model_word[i] = '0;
		avl_reset_n = 1'b0;
		avl_address = '0;
		avl_write = 1'b0;
		avl_read = 1'b0;
		avl_writedata = '0;
		capture_strobe_tracking = '0;

		reset_checks();
		fill_store();
		field_traffic();
		group_traffic();
		counter_traffic();
		saturation_check();
		shift_scans();
		update_scans();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: sources.f
+incdir+hdl
hdl/scc_pkg.sv
hdl/scc_avl_port.sv
hdl/scc_setting_store.sv
hdl/strobe_sample_counter.sv
hdl/scc_scan_engine.sv
hdl/scc_mgr.sv
verification/scc_mgr_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the scc_mgr testbench with Verilator, run it and judge the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module scc_mgr_tb -Mdir obj_dir
./obj_dir/Vscc_mgr_tb | tee sim.log

if grep -q "Simulation failed" sim.log
then
	echo "FAIL: see sim.log"
	exit 1
fi
echo "PASS"
